//--- axi_lite_if.sv
`default_nettype none
`timescale 1ns/1ns

interface axi_lite_if;
	import lsu_pkg::*;

	logic [XLEN-1:0] araddr;
	logic            arvalid;
	logic            arready;

	logic [XLEN-1:0] rdata;
	axi_resp_e       rresp;
	logic            rvalid;
	logic            rready;

	logic [XLEN-1:0] awaddr;
	logic            awvalid;
	logic            awready;

	logic [XLEN-1:0] wdata;
	mem_write_e      wstrb; // size code rather than byte mask
	logic            wvalid;
	logic            wready;

	axi_resp_e       bresp;
	logic            bvalid;
	logic            bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

endinterface

`default_nettype wire

//--- axi_lite_sram.sv
`default_nettype none
`timescale 1ns/1ns

module axi_lite_sram (
	input wire logic   clk,
	input wire logic   rst,
	axi_lite_if.slave  bus
);
	import lsu_pkg::*;

	logic [XLEN-1:0]        mem [MEM_WORDS];

	// read side
	logic                   rd_busy;
	logic [DLY_W-1:0]       rd_cnt;
	logic [MEM_IDX_W+1:0]   raddr_q;

	// write side
	logic                   aw_done;
	logic                   w_done;
	logic [DLY_W-1:0]       wr_cnt;
	logic [MEM_IDX_W+1:0]   waddr_q;
	logic [XLEN-1:0]        wdata_q;
	mem_write_e             wsize_q;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   wr_armed;

	// place sub-word data into the lane picked by the offset
	function automatic logic [XLEN-1:0] merge_word(
		input logic [XLEN-1:0] old_word,
		input logic [XLEN-1:0] data,
		input logic [1:0]      off,
		input mem_write_e      size
	);
		logic [XLEN-1:0] w;
		w = old_word;
		case (size)
			MEM_WRITE_BYTE: w[8*off +: 8] = data[7:0];
			MEM_WRITE_HALF: w[16*off[1] +: 16] = data[15:0];
			MEM_WRITE_WORD: w = data;
			default:        w = old_word;
		endcase
		return w;
	endfunction

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0; // memory starts cleared
	end

	assign bus.arready = !rd_busy;
	assign bus.awready = !aw_done;
	assign bus.wready  = !w_done;
	assign bus.rresp   = RESP_OKAY;
	assign bus.bresp   = RESP_OKAY;

	assign aw_hs    = bus.awvalid && bus.awready;
	assign w_hs     = bus.wvalid && bus.wready;
	assign wr_armed = aw_done && w_done && !bus.bvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_busy   <= 1'b0;
			rd_cnt    <= '0;
			bus.rvalid <= 1'b0;
		end else if (bus.arvalid && bus.arready) begin
			rd_busy <= 1'b1;
			rd_cnt  <= DLY_W'(RESP_DELAY - 1);
		end else if (bus.rvalid && bus.rready) begin
			rd_busy    <= 1'b0;
			bus.rvalid <= 1'b0;
		end else if (rd_busy && !bus.rvalid) begin
			if (rd_cnt == '0)
				bus.rvalid <= 1'b1;
			else
				rd_cnt <= rd_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.arvalid && bus.arready)
			raddr_q <= bus.araddr[MEM_IDX_W+1:0];
		if (rd_busy && !bus.rvalid && rd_cnt == '0)
			bus.rdata <= mem[raddr_q[MEM_IDX_W+1:2]] >> {raddr_q[1:0], 3'b000};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_done    <= 1'b0;
			w_done     <= 1'b0;
			wr_cnt     <= '0;
			bus.bvalid <= 1'b0;
		end else begin
			if (aw_hs)
				aw_done <= 1'b1;
			if (w_hs)
				w_done <= 1'b1;
			// last of the two request transfers starts the delay
			if ((aw_done || aw_hs) && (w_done || w_hs) && !(aw_done && w_done))
				wr_cnt <= DLY_W'(RESP_DELAY - 1);
			else if (wr_armed) begin
				if (wr_cnt == '0)
					bus.bvalid <= 1'b1;
				else
					wr_cnt <= wr_cnt - 1'b1;
			end
			if (bus.bvalid && bus.bready) begin
				bus.bvalid <= 1'b0;
				aw_done    <= 1'b0;
				w_done     <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			waddr_q <= bus.awaddr[MEM_IDX_W+1:0];
		if (w_hs) begin
			wdata_q <= bus.wdata;
			wsize_q <= bus.wstrb;
		end
		if (wr_armed && wr_cnt == '0) // commit as bvalid rises
			mem[waddr_q[MEM_IDX_W+1:2]] <= merge_word(mem[waddr_q[MEM_IDX_W+1:2]],
				wdata_q, waddr_q[1:0], wsize_q);
	end

endmodule

`default_nettype wire

//--- compile.f
lsu_pkg.sv
axi_lite_if.sv
lsu.sv
axi_lite_sram.sv
lsu_mem_top.sv
lsu_assertions.sv
tb_lsu_mem_top.sv

//--- lsu.sv
`default_nettype none
`timescale 1ns/1ns

module lsu (
	input  wire logic                     clk,
	input  wire logic                     rst,

	input  wire logic                     in_valid,
	output logic                          in_ready,
	input  wire logic [lsu_pkg::XLEN-1:0] in_pc,
	input  wire logic [lsu_pkg::XLEN-1:0] in_branch_target,
	input  wire logic [lsu_pkg::XLEN-1:0] in_result,
	input  wire logic [lsu_pkg::XLEN-1:0] in_store_data,
	input  wire lsu_pkg::mem_read_e       in_mem_read,
	input  wire lsu_pkg::mem_write_e      in_mem_write,
	input  wire logic [4:0]               in_rd,
	input  wire logic                     in_is_branch,
	input  wire logic                     in_ecall,
	input  wire logic                     in_mret,

	output logic                          out_valid,
	input  wire logic                     out_ready,
	output logic [lsu_pkg::XLEN-1:0]      out_pc,
	output logic [lsu_pkg::XLEN-1:0]      out_branch_target,
	output logic [lsu_pkg::XLEN-1:0]      out_result,
	output logic [4:0]                    out_rd,
	output logic                          out_is_branch,
	output logic                          out_ecall,
	output logic                          out_mret,

	axi_lite_if.master                    bus
);
	import lsu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_REQ,
		S_RD_RESP,
		S_WR_REQ,  // aw and w both pending
		S_WR_AW,   // only address left
		S_WR_W,    // only data left
		S_WR_RESP,
		S_WB
	} state_e;

	state_e          state;
	state_e          next_state;
	mem_read_e       rd_code_q;  // load code of the item in flight
	logic [XLEN-1:0] load_data;
	logic            r_done;

	// side fields pass straight through, upstream holds them
	assign out_pc            = in_pc;
	assign out_branch_target = in_branch_target;
	assign out_rd            = in_rd;
	assign out_is_branch     = in_is_branch;
	assign out_ecall         = in_ecall;
	assign out_mret          = in_mret;

	assign bus.araddr = in_result;
	assign bus.awaddr = in_result;
	assign bus.wdata  = in_store_data;
	assign bus.wstrb  = in_mem_write;

	// handshakes follow the state directly
	assign in_ready    = (state == S_IDLE);
	assign out_valid   = (state == S_WB);
	assign bus.arvalid = (state == S_RD_REQ);
	assign bus.rready  = (state == S_RD_RESP);
	assign bus.awvalid = (state == S_WR_REQ) || (state == S_WR_AW);
	assign bus.wvalid  = (state == S_WR_REQ) || (state == S_WR_W);
	assign bus.bready  = (state == S_WR_RESP);

	assign r_done = bus.rready && bus.rvalid && (bus.rresp == RESP_OKAY);

	assign out_result = (rd_code_q != MEM_READ_NONE) ? load_data : in_result;

	always_ff @(posedge clk) begin
		if (rst)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (in_valid) begin
					if (in_mem_read != MEM_READ_NONE)
						next_state = S_RD_REQ;
					else if (in_mem_write != MEM_WRITE_NONE)
						next_state = S_WR_REQ;
					else
						next_state = S_WB; // nothing to do on the bus
				end
			end
			S_RD_REQ:  if (bus.arready) next_state = S_RD_RESP;
			S_RD_RESP: if (r_done) next_state = S_WB;
			S_WR_REQ: begin
				case ({bus.awready, bus.wready})
					2'b11:   next_state = S_WR_RESP;
					2'b10:   next_state = S_WR_W;
					2'b01:   next_state = S_WR_AW;
					default: next_state = S_WR_REQ;
				endcase
			end
			S_WR_AW: if (bus.awready) next_state = S_WR_RESP;
			S_WR_W:  if (bus.wready) next_state = S_WR_RESP;
			S_WR_RESP: begin
				if (bus.bvalid && bus.bresp == RESP_OKAY)
					next_state = S_WB;
			end
			S_WB: if (out_ready) next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	// load code held from read entry until the item leaves
	always_ff @(posedge clk) begin
		if (rst)
			rd_code_q <= MEM_READ_NONE;
		else if (state == S_IDLE && next_state == S_RD_REQ)
			rd_code_q <= in_mem_read;
		else if (state == S_WB && out_ready)
			rd_code_q <= MEM_READ_NONE;
	end

	// slave already shifted the addressed byte down to bit 0
	always_ff @(posedge clk) begin
		if (r_done) begin
			case (rd_code_q)
				MEM_READ_BYTE:   load_data <= {{24{bus.rdata[7]}}, bus.rdata[7:0]};
				MEM_READ_HALF:   load_data <= {{16{bus.rdata[15]}}, bus.rdata[15:0]};
				MEM_READ_BYTE_U: load_data <= {24'b0, bus.rdata[7:0]};
				MEM_READ_HALF_U: load_data <= {16'b0, bus.rdata[15:0]};
				default:         load_data <= bus.rdata; // word
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lsu_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module lsu_assertions (
	input wire logic                       clk,
	input wire logic                       rst,
	input wire logic                       in_ready,
	input wire logic                       out_valid,
	input wire logic                       out_ready,
	input wire logic [3*lsu_pkg::XLEN+7:0] out_fields, // pc, target, result, rd, flags
	input wire logic                       arvalid,
	input wire logic                       arready,
	input wire logic                       awvalid,
	input wire logic                       awready,
	input wire logic                       wvalid,
	input wire logic                       wready
);

	int unsigned fail_count = 0; // polled by the testbench

	task automatic flag(input string msg);
		$error("%s", msg);
		fail_count++;
	endtask

	// a raised valid stays up until its transfer
	ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
		else flag("arvalid dropped before arready");
	aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
		else flag("awvalid dropped before awready");
	w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
		else flag("wvalid dropped before wready");
	out_hold: assert property (@(posedge clk) disable iff (rst) out_valid && !out_ready |=> out_valid)
		else flag("out_valid dropped before out_ready");

	// reads and writes never overlap
	rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(arvalid && (awvalid || wvalid)))
		else flag("arvalid together with a write request");

	out_in_excl: assert property (@(posedge clk) disable iff (rst) !(out_valid && in_ready))
		else flag("out_valid and in_ready high together");

	out_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> $stable(out_fields))
		else flag("out fields changed under back-pressure");

endmodule

bind lsu lsu_assertions u_lsu_assertions (
	.clk        (clk),
	.rst        (rst),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_fields ({out_pc, out_branch_target, out_result, out_rd,
		out_is_branch, out_ecall, out_mret}),
	.arvalid    (bus.arvalid),
	.arready    (bus.arready),
	.awvalid    (bus.awvalid),
	.awready    (bus.awready),
	.wvalid     (bus.wvalid),
	.wready     (bus.wready)
);

`default_nettype wire

//--- lsu_mem_top.sv
`default_nettype none
`timescale 1ns/1ns

module lsu_mem_top (
	input  wire logic                     clk,
	input  wire logic                     rst,

	input  wire logic                     in_valid,
	output logic                          in_ready,
	input  wire logic [lsu_pkg::XLEN-1:0] in_pc,
	input  wire logic [lsu_pkg::XLEN-1:0] in_branch_target,
	input  wire logic [lsu_pkg::XLEN-1:0] in_result,
	input  wire logic [lsu_pkg::XLEN-1:0] in_store_data,
	input  wire lsu_pkg::mem_read_e       in_mem_read,
	input  wire lsu_pkg::mem_write_e      in_mem_write,
	input  wire logic [4:0]               in_rd,
	input  wire logic                     in_is_branch,
	input  wire logic                     in_ecall,
	input  wire logic                     in_mret,

	output logic                          out_valid,
	input  wire logic                     out_ready,
	output logic [lsu_pkg::XLEN-1:0]      out_pc,
	output logic [lsu_pkg::XLEN-1:0]      out_branch_target,
	output logic [lsu_pkg::XLEN-1:0]      out_result,
	output logic [4:0]                    out_rd,
	output logic                          out_is_branch,
	output logic                          out_ecall,
	output logic                          out_mret
);

	axi_lite_if u_bus ();

	lsu u_lsu (
		.clk               (clk),
		.rst               (rst),
		.in_valid          (in_valid),
		.in_ready          (in_ready),
		.in_pc             (in_pc),
		.in_branch_target  (in_branch_target),
		.in_result         (in_result),
		.in_store_data     (in_store_data),
		.in_mem_read       (in_mem_read),
		.in_mem_write      (in_mem_write),
		.in_rd             (in_rd),
		.in_is_branch      (in_is_branch),
		.in_ecall          (in_ecall),
		.in_mret           (in_mret),
		.out_valid         (out_valid),
		.out_ready         (out_ready),
		.out_pc            (out_pc),
		.out_branch_target (out_branch_target),
		.out_result        (out_result),
		.out_rd            (out_rd),
		.out_is_branch     (out_is_branch),
		.out_ecall         (out_ecall),
		.out_mret          (out_mret),
		.bus               (u_bus.master)
	);

	// local memory answering the unit
	axi_lite_sram u_sram (
		.clk (clk),
		.rst (rst),
		.bus (u_bus.slave)
	);

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	localparam int XLEN = 32;

	// slave memory depth in words, index is address bits 9:2
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	// cycles from last request transfer to rvalid / bvalid
	localparam int RESP_DELAY = 2;
	localparam int DLY_W = $clog2(RESP_DELAY + 1);

	// load code from execute
	typedef enum logic [2:0] {
		MEM_READ_NONE   = 3'd0,
		MEM_READ_BYTE   = 3'd1,
		MEM_READ_HALF   = 3'd2,
		MEM_READ_WORD   = 3'd3,
		MEM_READ_BYTE_U = 3'd4,
		MEM_READ_HALF_U = 3'd5
	} mem_read_e;

	// store size code, carried on wstrb
	typedef enum logic [1:0] {
		MEM_WRITE_NONE = 2'd0,
		MEM_WRITE_BYTE = 2'd1,
		MEM_WRITE_HALF = 2'd2,
		MEM_WRITE_WORD = 2'd3
	} mem_write_e;

	// axi response code
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

endpackage

`default_nettype wire

//--- tb_lsu_mem_top.sv
`default_nettype none
`timescale 1ns/1ns

module tb_lsu_mem_top;
	import lsu_pkg::*;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] branch_target;
		logic            is_branch;
		logic            ecall;
		logic            mret;
	} ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [4:0]      rd;
		ctrl_t           ctrl;
	} expect_t;

	logic            clk;
	logic            rst;
	logic            in_valid;
	logic            in_ready;
	logic [XLEN-1:0] in_pc, in_branch_target, in_result, in_store_data;
	mem_read_e       in_mem_read;
	mem_write_e      in_mem_write;
	logic [4:0]      in_rd;
	logic            in_is_branch, in_ecall, in_mret;
	logic            out_valid;
	logic            out_ready;
	logic [XLEN-1:0] out_pc, out_branch_target, out_result;
	logic [4:0]      out_rd;
	logic            out_is_branch, out_ecall, out_mret;

	logic [XLEN-1:0] shadow [MEM_WORDS]; // model of the slave memory
	logic [31:0]     lfsr_state;
	expect_t         exp_q [$];
	string           test_name;
	int              n_checked;

	lsu_mem_top u_lsu_mem_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		if (exp !== act)
			stop_run($sformatf("error: %s result expected %h actual %h", name, exp, act));
	endtask

	task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
		if (exp !== act)
			stop_run($sformatf("error: %s rd expected %0d actual %0d", name, exp, act));
	endtask

	// pc, target, branch, ecall, mret as one hex value
	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		if (exp !== act)
			stop_run($sformatf("error: %s ctrl expected %h actual %h", name, exp, act));
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// lane by lane, a lane changes only when the store covers it
	function automatic logic [XLEN-1:0] merged_word(input logic [XLEN-1:0] old,
		input logic [XLEN-1:0] data, input logic [1:0] off, input mem_write_e size);
		logic [XLEN-1:0] w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (size == MEM_WRITE_WORD)
				w[8*b +: 8] = data[8*b +: 8];
			else if (size == MEM_WRITE_HALF && b / 2 == off[1])
				w[8*b +: 8] = data[8*(b%2) +: 8]; // low half of data, lane pair by bit 1
			else if (size == MEM_WRITE_BYTE && b == off)
				w[8*b +: 8] = data[7:0];
		end
		return w;
	endfunction

	// out_result for the item now on the in ports
	function automatic logic [XLEN-1:0] expect_result();
		logic [XLEN-1:0] sh;
		sh = shadow[in_result[MEM_IDX_W+1:2]] >> (8 * in_result[1:0]);
		case (in_mem_read)
			MEM_READ_BYTE:   return XLEN'($signed(sh[7:0]));
			MEM_READ_HALF:   return XLEN'($signed(sh[15:0]));
			MEM_READ_BYTE_U: return XLEN'(sh[7:0]);
			MEM_READ_HALF_U: return XLEN'(sh[15:0]);
			MEM_READ_WORD:   return sh;
			default:         return in_result; // plain item or store
		endcase
	endfunction

	function automatic expect_t observed();
		return {out_result, out_rd, out_pc, out_branch_target, out_is_branch, out_ecall, out_mret};
	endfunction

	// kind 0 plain, 1 load, 2 store
	task automatic set_fields(input int kind);
		logic [31:0] v;
		logic [1:0]  off;
		take_bits(32, v);
		in_pc = v;
		take_bits(32, v);
		in_branch_target = v;
		take_bits(32, v);
		in_store_data = v;
		take_bits(32, v);
		in_result = v;
		take_bits(8, v);
		{in_rd, in_is_branch, in_ecall, in_mret} = v[7:0];
		in_mem_read  = MEM_READ_NONE;
		in_mem_write = MEM_WRITE_NONE;
		take_bits(3, v);
		if (kind == 1)
			in_mem_read = mem_read_e'(3'(v % 5) + 3'd1); // byte .. half_u
		else if (kind == 2)
			in_mem_write = mem_write_e'(2'(v % 3) + 2'd1);
		take_bits(MEM_IDX_W + 2, v);
		off = v[1:0];
		if (in_mem_read inside {MEM_READ_HALF, MEM_READ_HALF_U} || in_mem_write == MEM_WRITE_HALF)
			off[0] = 1'b0; // halves stay even
		if (in_mem_read == MEM_READ_WORD || in_mem_write == MEM_WRITE_WORD)
			off = 2'b00;
		if (kind != 0)
			in_result = XLEN'({v[MEM_IDX_W+1:2], off});
	endtask

	// runs from a falling edge to the falling edge after the item left
	task automatic drive_item(input int stall);
		expect_t e;
		expect_t cur;
		logic    is_mem;
		int      t;
		e = {expect_result(), in_rd, in_pc, in_branch_target, in_is_branch, in_ecall, in_mret};
		is_mem = (in_mem_read != MEM_READ_NONE) || (in_mem_write != MEM_WRITE_NONE);
		if (in_mem_read == MEM_READ_NONE && in_mem_write != MEM_WRITE_NONE)
			shadow[in_result[MEM_IDX_W+1:2]] = merged_word(shadow[in_result[MEM_IDX_W+1:2]],
				in_store_data, in_result[1:0], in_mem_write);
		exp_q.push_back(e);
		in_valid  = 1'b1;
		out_ready = (stall == 0);
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > 200)
				stop_run("timeout waiting for in_ready");
		end while (!in_ready);
		@(negedge clk);
		in_valid = 1'b0; // fields stay put until write-back takes the item
		t = 1;
		while (!out_valid) begin
			@(negedge clk);
			t++;
			if (t > 200)
				stop_run("timeout waiting for out_valid");
		end
		if (is_mem ? (t < RESP_DELAY + 2) : (t != 1))
			stop_run($sformatf("%s: out_valid came %0d cycles after acceptance", test_name, t));
		repeat (stall) begin
			@(negedge clk);
			cur = observed();
			if (!out_valid || in_ready)
				stop_run("out_valid or in_ready changed while out_ready was low");
			check_result(test_name, e.result, cur.result);
			check_rd(test_name, e.rd, cur.rd);
			check_ctrl(test_name, e.ctrl, cur.ctrl);
		end
		out_ready = 1'b1;
		@(negedge clk);
		if (out_valid || !in_ready)
			stop_run("item did not leave on the first cycle with out_ready high");
	endtask

	task automatic mem_op(input mem_read_e r, input mem_write_e w, input logic [XLEN-1:0] addr,
		input logic [XLEN-1:0] data);
		set_fields(0);
		in_mem_read   = r;
		in_mem_write  = w;
		in_result     = addr;
		in_store_data = data;
		drive_item(0);
	endtask

	// outputs sampled at the edge of the write-back handshake
	always @(posedge clk) begin : compare_outputs
		expect_t e;
		expect_t got;
		if (!rst && out_valid && out_ready) begin
			if (exp_q.size() == 0)
				stop_run("write-back handshake with no item in flight");
			else begin
				e = exp_q.pop_front();
				got = observed();
				check_result(test_name, e.result, got.result);
				check_rd(test_name, e.rd, got.rd);
				check_ctrl(test_name, e.ctrl, got.ctrl);
				n_checked++;
			end
		end
	end

	// a failed protocol assertion ends the run at once
	always @(negedge clk) begin : watch_assertions
		if (u_lsu_mem_top.u_lsu.u_lsu_assertions.fail_count != 0)
			stop_run("protocol assertion failed in lsu");
	end

	initial begin : main
		logic [31:0]     v;
		logic [XLEN-1:0] addr;
		lfsr_state = 32'h2b383dba;
		n_checked  = 0;
		test_name  = "reset";
		rst        = 1'b1;
		in_valid   = 1'b0;
		out_ready  = 1'b0;
		set_fields(0);
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = '0; // slave memory starts cleared
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "passthru";
		repeat (6) begin
			set_fields(0);
			drive_item(0);
		end

		test_name = "word_store_load";
		repeat (4) begin
			take_bits(MEM_IDX_W, v);
			addr = XLEN'({v[MEM_IDX_W-1:0], 2'b00});
			take_bits(32, v);
			mem_op(MEM_READ_NONE, MEM_WRITE_WORD, addr, v);
			mem_op(MEM_READ_WORD, MEM_WRITE_NONE, addr, '0);
		end

		// bytes at 0..3, halves at 0 and 2, each over a fresh known word
		test_name = "subword_merge";
		for (int k = 0; k < 6; k++) begin
			take_bits(MEM_IDX_W, v);
			addr = XLEN'({v[MEM_IDX_W-1:0], 2'b00});
			mem_op(MEM_READ_NONE, MEM_WRITE_WORD, addr, 32'ha5c3_0f96);
			take_bits(32, v);
			if (k < 4)
				mem_op(MEM_READ_NONE, MEM_WRITE_BYTE, addr + k, v);
			else
				mem_op(MEM_READ_NONE, MEM_WRITE_HALF, addr + 2 * (k - 4), v);
			mem_op(MEM_READ_WORD, MEM_WRITE_NONE, addr, '0);
		end

		test_name = "load_extend";
		addr = 32'h0000_0140;
		mem_op(MEM_READ_NONE, MEM_WRITE_WORD, addr, 32'h9cf3_a587); // bit 7 set in every byte
		for (int k = 0; k < 4; k++) begin
			mem_op(MEM_READ_BYTE, MEM_WRITE_NONE, addr + k, '0);
			mem_op(MEM_READ_BYTE_U, MEM_WRITE_NONE, addr + k, '0);
			if (k % 2 == 0) begin
				mem_op(MEM_READ_HALF, MEM_WRITE_NONE, addr + k, '0);
				mem_op(MEM_READ_HALF_U, MEM_WRITE_NONE, addr + k, '0);
			end
		end
		mem_op(MEM_READ_WORD, MEM_WRITE_NONE, addr, '0);

		test_name = "backpressure";
		repeat (8) begin
			take_bits(2, v);
			set_fields(v % 3);
			take_bits(4, v);
			drive_item(1 + v[3:0]);
		end

		test_name = "random_mix";
		repeat (300) begin
			take_bits(2, v);
			set_fields(v % 3);
			take_bits(3, v);
			drive_item(v[2] ? 0 : v[1:0]); // occasional short stall
		end

		if (exp_q.size() != 0)
			stop_run("items left without a write-back handshake");
		else if (u_lsu_mem_top.u_lsu.u_lsu_assertions.fail_count != 0)
			stop_run($sformatf("%0d assertion failures",
				u_lsu_mem_top.u_lsu.u_lsu_assertions.fail_count));
		else begin
			$display("%0d items checked", n_checked);
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire
